// File: Makefile
VERILATOR  ?= verilator
FILELIST   := filelist.f
TOP        := rename_core_tb
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Simulation PASSED
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing -Wno-fatal -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: filelist.f
hdl/core_pkg.sv
hdl/pipe_if.sv
hdl/rename_table.sv
hdl/phys_reg_file.sv
hdl/instr_decoder.sv
hdl/alu_execute.sv
hdl/result_writeback.sv
hdl/rename_core_top.sv
verification/rename_core_tb.sv

// File: hdl/alu_execute.sv
`timescale 1ns/1ns

module alu_execute (
    input  logic            CLK,
    input  logic            RESET,
    decode_bus_if.consumer  dec,
    input  logic            fwd_valid,
    input  core_pkg::preg_t fwd_tag,
    input  core_pkg::word_t fwd_data,
    exec_bus_if.producer    exe
);
    import core_pkg::*;

    word_t src_a;
    word_t src_b;
    word_t opnd_b;
    word_t alu_res;
    logic  take;
    logic  is_link;

    // **************************************************************************
    // Operand forwarding
    // **************************************************************************
    // Own last result is newest, then the result register
    function automatic word_t forward(input preg_t tag, input word_t rf_data);
        if (exe.valid && exe.reg_write && (exe.dest_tag == tag)) begin
            return exe.data;
        end else if (fwd_valid && (fwd_tag == tag)) begin
            return fwd_data;
        end
        return rf_data;
    endfunction

    assign src_a  = forward(dec.src_a_tag, dec.opnd_a);
    assign src_b  = forward(dec.src_b_tag, dec.opnd_b);
    assign opnd_b = dec.use_imm ? dec.imm : src_b;

    always_comb begin
        case (dec.alu_op)
            ALU_ADD: alu_res = src_a + opnd_b;
            ALU_SUB: alu_res = src_a - opnd_b;
            ALU_AND: alu_res = src_a & opnd_b;
            ALU_OR:  alu_res = src_a | opnd_b;
            ALU_XOR: alu_res = src_a ^ opnd_b;
            ALU_SLT: alu_res = {31'b0, $signed(src_a) < $signed(opnd_b)};
            ALU_SLL: alu_res = opnd_b << dec.shamt;
            ALU_SRL: alu_res = opnd_b >> dec.shamt;
            ALU_LUI: alu_res = {opnd_b[15:0], 16'h0000};
            default: alu_res = '0;
        endcase
    end

    // Branch condition compares the raw register operands
    always_comb begin
        case (dec.branch)
            BR_EQ:            take = (src_a == src_b);
            BR_NE:            take = (src_a != src_b);
            BR_JUMP, BR_JREG: take = 1'b1;
            default:          take = 1'b0;
        endcase
    end

    // Only JAL is a jump that also writes
    assign is_link = (dec.branch == BR_JUMP) && dec.reg_write;

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            exe.valid <= 1'b0;
        end else begin
            exe.valid <= dec.valid;
        end
    end

    always_ff @(posedge CLK) begin
        exe.pc          <= dec.pc;
        exe.data        <= is_link ? dec.link_addr : alu_res;
        exe.dest_areg   <= dec.dest_areg;
        exe.dest_tag    <= dec.dest_tag;
        exe.old_tag     <= dec.old_tag;
        exe.reg_write   <= dec.reg_write;
        exe.illegal     <= dec.illegal;
        exe.alt_pc      <= (dec.branch == BR_JREG) ? src_a : dec.target;
        exe.take_branch <= take;
    end

endmodule

// File: hdl/core_pkg.sv
package core_pkg;

    // **************************************************************************
    // Widths and sizes
    // **************************************************************************
    typedef logic [31:0] word_t;
    typedef logic [4:0]  areg_t;
    typedef logic [5:0]  preg_t;

    localparam int NUM_PREGS  = 64;
    localparam int NUM_AREGS  = 32;
    // Tags 32 to 63 start out free
    localparam int FREE_DEPTH = 32;

    localparam areg_t LINK_AREG = 5'd31;

    // **************************************************************************
    // Opcode and function encodings
    // **************************************************************************
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_JAL   = 6'h03;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LUI   = 6'h0f;

    localparam logic [5:0] FN_SLL   = 6'h00;
    localparam logic [5:0] FN_SRL   = 6'h02;
    localparam logic [5:0] FN_JR    = 6'h08;
    localparam logic [5:0] FN_ADDU  = 6'h21;
    localparam logic [5:0] FN_SUBU  = 6'h23;
    localparam logic [5:0] FN_AND   = 6'h24;
    localparam logic [5:0] FN_OR    = 6'h25;
    localparam logic [5:0] FN_XOR   = 6'h26;
    localparam logic [5:0] FN_SLT   = 6'h2a;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLL, ALU_SRL, ALU_LUI
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_JUMP, BR_JREG
    } branch_e;

endpackage

// File: hdl/instr_decoder.sv
`timescale 1ns/1ns

module instr_decoder (
    input  logic            CLK,
    input  logic            RESET,
    input  logic            instr_valid,
    input  core_pkg::word_t instr,
    input  core_pkg::word_t instr_pc,
    output logic            alloc,
    input  core_pkg::preg_t alloc_tag,
    output core_pkg::areg_t map_areg_a,
    output core_pkg::areg_t map_areg_b,
    input  core_pkg::preg_t map_tag_a,
    input  core_pkg::preg_t map_tag_b,
    output core_pkg::areg_t map_dest,
    input  core_pkg::preg_t map_old_tag,
    output core_pkg::preg_t rd_tag_a,
    output core_pkg::preg_t rd_tag_b,
    input  core_pkg::word_t rd_data_a,
    input  core_pkg::word_t rd_data_b,
    decode_bus_if.producer  dec
);
    import core_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    word_t      pc_plus4;
    word_t      imm_sext;
    word_t      imm_zext;
    word_t      br_target;
    word_t      jmp_target;
    alu_op_e    alu_op;
    branch_e    branch;
    logic       use_imm;
    logic       sign_ext;
    logic       writes;
    logic       illegal;
    areg_t      dest;
    logic       reg_write;

    // **************************************************************************
    // Field split, immediates and targets
    // **************************************************************************
    assign opcode     = instr[31:26];
    assign funct      = instr[5:0];
    assign pc_plus4   = instr_pc + 32'd4;
    assign imm_sext   = {{16{instr[15]}}, instr[15:0]};
    assign imm_zext   = {16'h0000, instr[15:0]};
    assign br_target  = pc_plus4 + {imm_sext[29:0], 2'b00};
    // Jump stays inside the 256 MB region of the delay slot
    assign jmp_target = {pc_plus4[31:28], instr[25:0], 2'b00};

    always_comb begin
        alu_op   = ALU_ADD;
        branch   = BR_NONE;
        use_imm  = 1'b0;
        sign_ext = 1'b1;
        writes   = 1'b0;
        illegal  = 1'b0;
        dest     = instr[20:16];
        case (opcode)
            OP_RTYPE: begin
                dest   = instr[15:11];
                writes = 1'b1;
                case (funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLL:  alu_op = ALU_SLL;
                    FN_SRL:  alu_op = ALU_SRL;
                    FN_JR: begin
                        branch = BR_JREG;
                        writes = 1'b0;
                    end
                    default: begin
                        writes  = 1'b0;
                        illegal = 1'b1;
                    end
                endcase
            end
            OP_ADDIU: begin
                use_imm = 1'b1;
                writes  = 1'b1;
            end
            OP_ANDI, OP_ORI, OP_LUI: begin
                alu_op   = (opcode == OP_ANDI) ? ALU_AND :
                           (opcode == OP_ORI)  ? ALU_OR  : ALU_LUI;
                use_imm  = 1'b1;
                sign_ext = 1'b0;
                writes   = 1'b1;
            end
            OP_BEQ: branch = BR_EQ;
            OP_BNE: branch = BR_NE;
            OP_J:   branch = BR_JUMP;
            OP_JAL: begin
                branch = BR_JUMP;
                dest   = LINK_AREG;
                writes = 1'b1;
            end
            default: illegal = 1'b1;
        endcase
    end

    // Register 0 never gets a new tag
    assign reg_write  = writes && (dest != '0);
    assign alloc      = instr_valid && reg_write;
    assign map_dest   = dest;
    assign map_areg_a = instr[25:21];
    assign map_areg_b = instr[20:16];
    assign rd_tag_a   = map_tag_a;
    assign rd_tag_b   = map_tag_b;

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            dec.valid <= 1'b0;
        end else begin
            dec.valid <= instr_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (instr_valid) begin
            dec.pc        <= instr_pc;
            dec.alu_op    <= alu_op;
            dec.branch    <= branch;
            dec.src_a_tag <= map_tag_a;
            dec.src_b_tag <= map_tag_b;
            dec.opnd_a    <= rd_data_a;
            dec.opnd_b    <= rd_data_b;
            dec.use_imm   <= use_imm;
            dec.imm       <= sign_ext ? imm_sext : imm_zext;
            dec.shamt     <= instr[10:6];
            dec.target    <= (branch == BR_JUMP) ? jmp_target : br_target;
            dec.dest_areg <= reg_write ? dest : '0;
            dec.dest_tag  <= alloc_tag;
            dec.old_tag   <= map_old_tag;
            dec.reg_write <= reg_write;
            dec.link_addr <= instr_pc + 32'd8;
            dec.illegal   <= illegal;
        end
    end

endmodule

// File: hdl/phys_reg_file.sv
`timescale 1ns/1ns

module phys_reg_file (
    input  logic            CLK,
    input  logic            RESET,
    input  core_pkg::preg_t rd_tag_a,
    input  core_pkg::preg_t rd_tag_b,
    output core_pkg::word_t rd_data_a,
    output core_pkg::word_t rd_data_b,
    input  logic            wr_en,
    input  core_pkg::preg_t wr_tag,
    input  core_pkg::word_t wr_data
);
    import core_pkg::*;

    word_t regs_q [NUM_PREGS];

    // Tag 0 reads zero and a same-cycle write passes straight through
    function automatic word_t read_port(input preg_t tag);
        if (tag == '0) begin
            return '0;
        end else if (wr_en && (wr_tag == tag)) begin
            return wr_data;
        end
        return regs_q[tag];
    endfunction

    assign rd_data_a = read_port(rd_tag_a);
    assign rd_data_b = read_port(rd_tag_b);

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < NUM_PREGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en && (wr_tag != '0)) begin
            regs_q[wr_tag] <= wr_data;
        end
    end

endmodule

// File: hdl/pipe_if.sv
`timescale 1ns/1ns

// Decoded and renamed instruction, decode to execute
interface decode_bus_if;
    import core_pkg::*;

    logic       valid;
    word_t      pc;
    alu_op_e    alu_op;
    branch_e    branch;
    preg_t      src_a_tag;
    preg_t      src_b_tag;
    word_t      opnd_a;
    word_t      opnd_b;
    logic       use_imm;
    word_t      imm;
    logic [4:0] shamt;
    word_t      target;
    areg_t      dest_areg;
    preg_t      dest_tag;
    preg_t      old_tag;
    logic       reg_write;
    word_t      link_addr;
    logic       illegal;

    modport producer (output valid, pc, alu_op, branch, src_a_tag, src_b_tag, opnd_a, opnd_b,
                      use_imm, imm, shamt, target, dest_areg, dest_tag, old_tag, reg_write,
                      link_addr, illegal);
    modport consumer (input valid, pc, alu_op, branch, src_a_tag, src_b_tag, opnd_a, opnd_b,
                      use_imm, imm, shamt, target, dest_areg, dest_tag, old_tag, reg_write,
                      link_addr, illegal);
endinterface

// Executed instruction, execute to result
interface exec_bus_if;
    import core_pkg::*;

    logic  valid;
    word_t pc;
    word_t data;
    areg_t dest_areg;
    preg_t dest_tag;
    preg_t old_tag;
    logic  reg_write;
    logic  illegal;
    word_t alt_pc;
    logic  take_branch;

    modport producer (output valid, pc, data, dest_areg, dest_tag, old_tag, reg_write,
                      illegal, alt_pc, take_branch);
    modport consumer (input valid, pc, data, dest_areg, dest_tag, old_tag, reg_write,
                      illegal, alt_pc, take_branch);
endinterface

// File: hdl/rename_core_top.sv
`timescale 1ns/1ns

module rename_core_top (
    input  logic            CLK,
    input  logic            RESET,
    input  logic            instr_valid,
    input  core_pkg::word_t instr,
    input  core_pkg::word_t instr_pc,
    output logic            result_valid,
    output core_pkg::word_t result_pc,
    output core_pkg::areg_t result_reg,
    output core_pkg::word_t result_data,
    output core_pkg::word_t alt_pc,
    output logic            request_alt_pc,
    output logic            illegal_instr
);
    import core_pkg::*;

    logic  alloc;
    preg_t alloc_tag;
    areg_t map_areg_a;
    areg_t map_areg_b;
    preg_t map_tag_a;
    preg_t map_tag_b;
    areg_t map_dest;
    preg_t map_old_tag;
    preg_t rd_tag_a;
    preg_t rd_tag_b;
    word_t rd_data_a;
    word_t rd_data_b;
    logic  wr_en;
    preg_t wr_tag;
    word_t wr_data;
    logic  free_valid;
    preg_t free_tag;

    decode_bus_if dec_bus ();
    exec_bus_if   exe_bus ();

    instr_decoder u_decoder (
        .CLK         (CLK),
        .RESET       (RESET),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .alloc       (alloc),
        .alloc_tag   (alloc_tag),
        .map_areg_a  (map_areg_a),
        .map_areg_b  (map_areg_b),
        .map_tag_a   (map_tag_a),
        .map_tag_b   (map_tag_b),
        .map_dest    (map_dest),
        .map_old_tag (map_old_tag),
        .rd_tag_a    (rd_tag_a),
        .rd_tag_b    (rd_tag_b),
        .rd_data_a   (rd_data_a),
        .rd_data_b   (rd_data_b),
        .dec         (dec_bus.producer)
    );

    rename_table u_rename (
        .CLK         (CLK),
        .RESET       (RESET),
        .map_areg_a  (map_areg_a),
        .map_areg_b  (map_areg_b),
        .map_tag_a   (map_tag_a),
        .map_tag_b   (map_tag_b),
        .alloc       (alloc),
        .alloc_tag   (alloc_tag),
        .map_dest    (map_dest),
        .map_old_tag (map_old_tag),
        .free_valid  (free_valid),
        .free_tag    (free_tag)
    );

    phys_reg_file u_prf (
        .CLK       (CLK),
        .RESET     (RESET),
        .rd_tag_a  (rd_tag_a),
        .rd_tag_b  (rd_tag_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .wr_en     (wr_en),
        .wr_tag    (wr_tag),
        .wr_data   (wr_data)
    );

    alu_execute u_execute (
        .CLK       (CLK),
        .RESET     (RESET),
        .dec       (dec_bus.consumer),
        .fwd_valid (wr_en),
        .fwd_tag   (wr_tag),
        .fwd_data  (wr_data),
        .exe       (exe_bus.producer)
    );

    result_writeback u_result (
        .CLK            (CLK),
        .RESET          (RESET),
        .exe            (exe_bus.consumer),
        .wr_en          (wr_en),
        .wr_tag         (wr_tag),
        .wr_data        (wr_data),
        .free_valid     (free_valid),
        .free_tag       (free_tag),
        .result_valid   (result_valid),
        .result_pc      (result_pc),
        .result_reg     (result_reg),
        .result_data    (result_data),
        .alt_pc         (alt_pc),
        .request_alt_pc (request_alt_pc),
        .illegal_instr  (illegal_instr)
    );

endmodule

// File: hdl/rename_table.sv
`timescale 1ns/1ns

module rename_table (
    input  logic            CLK,
    input  logic            RESET,
    input  core_pkg::areg_t map_areg_a,
    input  core_pkg::areg_t map_areg_b,
    output core_pkg::preg_t map_tag_a,
    output core_pkg::preg_t map_tag_b,
    input  logic            alloc,
    output core_pkg::preg_t alloc_tag,
    input  core_pkg::areg_t map_dest,
    output core_pkg::preg_t map_old_tag,
    input  logic            free_valid,
    input  core_pkg::preg_t free_tag
);
    import core_pkg::*;

    preg_t                         map_q  [NUM_AREGS];
    preg_t                         free_q [FREE_DEPTH];
    logic [$clog2(FREE_DEPTH)-1:0] head;
    logic [$clog2(FREE_DEPTH)-1:0] tail;

    // Lookups see the map before this cycle's allocation
    assign map_tag_a   = map_q[map_areg_a];
    assign map_tag_b   = map_q[map_areg_b];
    assign map_old_tag = map_q[map_dest];
    assign alloc_tag   = free_q[head];

    // **************************************************************************
    // Map update and circular free list
    // **************************************************************************
    // Head equal to tail means the list is full
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < NUM_AREGS; i++) begin
                map_q[i] <= preg_t'(i);
            end
            for (int i = 0; i < FREE_DEPTH; i++) begin
                free_q[i] <= preg_t'(NUM_AREGS + i);
            end
            head <= '0;
            tail <= '0;
        end else begin
            if (alloc) begin
                map_q[map_dest] <= free_q[head];
                head            <= head + 1'b1;
            end
            if (free_valid) begin
                free_q[tail] <= free_tag;
                tail         <= tail + 1'b1;
            end
        end
    end

endmodule

// File: hdl/result_writeback.sv
`timescale 1ns/1ns

module result_writeback (
    input  logic            CLK,
    input  logic            RESET,
    exec_bus_if.consumer    exe,
    output logic            wr_en,
    output core_pkg::preg_t wr_tag,
    output core_pkg::word_t wr_data,
    output logic            free_valid,
    output core_pkg::preg_t free_tag,
    output logic            result_valid,
    output core_pkg::word_t result_pc,
    output core_pkg::areg_t result_reg,
    output core_pkg::word_t result_data,
    output core_pkg::word_t alt_pc,
    output logic            request_alt_pc,
    output logic            illegal_instr
);
    import core_pkg::*;

    preg_t old_tag_q;

    // Strobes last one cycle per retired instruction
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            result_valid   <= 1'b0;
            request_alt_pc <= 1'b0;
            illegal_instr  <= 1'b0;
            wr_en          <= 1'b0;
        end else begin
            result_valid   <= exe.valid;
            request_alt_pc <= exe.valid && exe.take_branch;
            illegal_instr  <= exe.valid && exe.illegal;
            wr_en          <= exe.valid && exe.reg_write;
        end
    end

    always_ff @(posedge CLK) begin
        result_pc   <= exe.pc;
        result_reg  <= exe.dest_areg;
        result_data <= exe.data;
        alt_pc      <= exe.alt_pc;
        wr_tag      <= exe.dest_tag;
        old_tag_q   <= exe.old_tag;
    end

    // File write and tag return both land on the next edge
    assign wr_data    = result_data;
    assign free_valid = wr_en;
    assign free_tag   = old_tag_q;

endmodule

// File: verification/rename_core_tb.sv
`timescale 1ns/1ns

module rename_core_tb;
    import core_pkg::*;

    localparam int          CLK_PERIOD   = 4;
    localparam int          RESET_CYCLES = 10;
    localparam int          NUM_DIRECTED = 14;
    localparam int          NUM_RANDOM   = 400;
    localparam int          NUM_INSTR    = NUM_DIRECTED + NUM_RANDOM + NUM_AREGS - 1;
    localparam int          LIMIT_CYCLES = NUM_INSTR * 4 + 50;
    localparam logic [31:0] LFSR_SEED    = 32'h22b6_0961;
    localparam logic [31:0] LFSR_MASK    = 32'hd000_0001;

    localparam logic [5:0] ALU_FUNCTS [8] = '{
        FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT, FN_SLL, FN_SRL
    };

    typedef struct packed {
        word_t pc;
        areg_t dest;
        word_t data;
        logic  take;
        word_t alt_pc;
        logic  illegal;
    } expect_t;

    logic  CLK;
    logic  RESET;
    logic  instr_valid;
    word_t instr;
    word_t instr_pc;
    logic  result_valid;
    word_t result_pc;
    areg_t result_reg;
    word_t result_data;
    word_t alt_pc;
    logic  request_alt_pc;
    logic  illegal_instr;

    logic [31:0] lfsr;
    word_t       arch_regs [NUM_AREGS];
    expect_t     expect_q [$];
    string       label_q [$];
    time         issue_time_q [$];
    string       test_name;
    word_t       next_pc;
    int          issued;
    int          checks;
    int          value_errors;
    int          other_errors;

    rename_core_top dut (
        .CLK            (CLK),
        .RESET          (RESET),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .instr_pc       (instr_pc),
        .result_valid   (result_valid),
        .result_pc      (result_pc),
        .result_reg     (result_reg),
        .result_data    (result_data),
        .alt_pc         (alt_pc),
        .request_alt_pc (request_alt_pc),
        .illegal_instr  (illegal_instr)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    // **************************************************************************
    // Random bits and instruction encoding
    // **************************************************************************
    // Galois LFSR stepped once per bit
    function automatic word_t lfsr_take(input int nbits);
        word_t val;
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_MASK) : (lfsr >> 1);
        end
        return val;
    endfunction

    function automatic word_t enc_r(input logic [5:0] fn, input areg_t rs, input areg_t rt,
                                    input areg_t rd, input logic [4:0] sh);
        return {OP_RTYPE, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t enc_i(input logic [5:0] op, input areg_t rs, input areg_t rt,
                                    input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t enc_j(input logic [5:0] op, input logic [25:0] idx);
        return {op, idx};
    endfunction

    // Unknown opcode or an R-type with an unknown function
    function automatic word_t undefined_encoding();
        logic [5:0] op;
        logic [5:0] fn;
        if (lfsr_take(1) == 32'd1) begin
            op = 6'(lfsr_take(6));
            while (op inside {OP_RTYPE, OP_J, OP_JAL, OP_BEQ, OP_BNE, OP_ADDIU,
                              OP_ANDI, OP_ORI, OP_LUI}) begin
                op = 6'(lfsr_take(6));
            end
            return {op, 26'(lfsr_take(26))};
        end
        fn = 6'(lfsr_take(6));
        while (fn inside {FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT,
                          FN_SLL, FN_SRL, FN_JR}) begin
            fn = 6'(lfsr_take(6));
        end
        return {OP_RTYPE, 20'(lfsr_take(20)), fn};
    endfunction

    // Registers 0 to 7 only so that neighbours often depend on each other
    function automatic word_t random_instr();
        logic [3:0]  kind;
        areg_t       rs;
        areg_t       rt;
        areg_t       rd;
        logic [15:0] imm;
        word_t       ins;
        kind = 4'(lfsr_take(4));
        rs   = areg_t'(lfsr_take(3));
        rt   = areg_t'(lfsr_take(3));
        rd   = areg_t'(lfsr_take(3));
        imm  = 16'(lfsr_take(16));
        case (kind)
            4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5: begin
                ins = enc_r(ALU_FUNCTS[3'(lfsr_take(3))], rs, rt, rd, 5'(lfsr_take(5)));
            end
            4'd6, 4'd7: ins = enc_i(OP_ADDIU, rs, rt, imm);
            4'd8:       ins = enc_i(OP_ANDI, rs, rt, imm);
            4'd9:       ins = enc_i(OP_ORI, rs, rt, imm);
            4'd10:      ins = enc_i(OP_LUI, 5'd0, rt, imm);
            4'd11:      ins = enc_i(OP_BEQ, rs, rt, imm);
            4'd12:      ins = enc_i(OP_BNE, rs, rt, imm);
            4'd13: begin
                ins = enc_j((lfsr_take(1) == 32'd1) ? OP_JAL : OP_J, 26'(lfsr_take(26)));
            end
            4'd14:      ins = enc_r(FN_JR, rs, 5'd0, 5'd0, 5'd0);
            default:    ins = undefined_encoding();
        endcase
        return ins;
    endfunction

    // **************************************************************************
    // Reference model
    // **************************************************************************
    task automatic model_instr(input word_t ins, input word_t pc);
        logic [5:0] op;
        areg_t      rs;
        areg_t      rt;
        areg_t      dest;
        word_t      a;
        word_t      b;
        word_t      sext;
        word_t      zext;
        word_t      pc4;
        logic       writes;
        expect_t    e;
        op     = ins[31:26];
        rs     = ins[25:21];
        rt     = ins[20:16];
        a      = arch_regs[rs];
        b      = arch_regs[rt];
        sext   = {{16{ins[15]}}, ins[15:0]};
        zext   = {16'h0000, ins[15:0]};
        pc4    = pc + 32'd4;
        dest   = rt;
        writes = 1'b0;
        e      = '0;
        e.pc   = pc;
        case (op)
            OP_RTYPE: begin
                dest   = ins[15:11];
                writes = 1'b1;
                case (ins[5:0])
                    FN_ADDU: e.data = a + b;
                    FN_SUBU: e.data = a - b;
                    FN_AND:  e.data = a & b;
                    FN_OR:   e.data = a | b;
                    FN_XOR:  e.data = a ^ b;
                    FN_SLT:  e.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    FN_SLL:  e.data = b << ins[10:6];
                    FN_SRL:  e.data = b >> ins[10:6];
                    FN_JR: begin
                        writes   = 1'b0;
                        e.take   = 1'b1;
                        e.alt_pc = a;
                    end
                    default: begin
                        writes    = 1'b0;
                        e.illegal = 1'b1;
                    end
                endcase
            end
            OP_ADDIU: begin
                writes = 1'b1;
                e.data = a + sext;
            end
            OP_ANDI: begin
                writes = 1'b1;
                e.data = a & zext;
            end
            OP_ORI: begin
                writes = 1'b1;
                e.data = a | zext;
            end
            OP_LUI: begin
                writes = 1'b1;
                e.data = {ins[15:0], 16'h0000};
            end
            OP_BEQ, OP_BNE: begin
                e.take   = (op == OP_BEQ) ? (a == b) : (a != b);
                e.alt_pc = pc4 + {sext[29:0], 2'b00};
            end
            OP_J, OP_JAL: begin
                e.take   = 1'b1;
                e.alt_pc = {pc4[31:28], ins[25:0], 2'b00};
                if (op == OP_JAL) begin
                    writes = 1'b1;
                    dest   = 5'd31;
                    e.data = pc + 32'd8;
                end
            end
            default: e.illegal = 1'b1;
        endcase
        // Register 0 is never written
        if (writes && (dest != '0)) begin
            arch_regs[dest] = e.data;
            e.dest          = dest;
        end
        expect_q.push_back(e);
        label_q.push_back($sformatf("%s #%0d", test_name, issued));
        issued++;
    endtask

    // **************************************************************************
    // Drive, compare and retire
    // **************************************************************************
    task automatic issue(input word_t ins);
        @(negedge CLK);
        instr_valid = 1'b1;
        instr       = ins;
        instr_pc    = next_pc;
        model_instr(ins, next_pc);
        issue_time_q.push_back($time);
        next_pc = next_pc + 32'd4;
    endtask

    task automatic idle_cycle();
        @(negedge CLK);
        instr_valid = 1'b0;
    endtask

    task automatic compare_value(input string name, input word_t expected, input word_t actual);
        checks++;
        if (actual !== expected) begin
            value_errors++;
            $display("** Error %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
        end
    endtask

    task automatic retire_check();
        expect_t e;
        string   label;
        time     issued_at;
        if (expect_q.size() == 0) begin
            other_errors++;
            $display("A result retired at %0t with no instruction outstanding", $time);
        end else begin
            e         = expect_q.pop_front();
            label     = label_q.pop_front();
            issued_at = issue_time_q.pop_front();
            // Three edges from acceptance to the result strobe
            compare_value({label, " latency"}, 32'd3,
                          32'(($time - issued_at) / CLK_PERIOD));
            compare_value({label, " pc"}, e.pc, result_pc);
            compare_value({label, " reg"}, 32'(e.dest), 32'(result_reg));
            if (e.dest != '0) begin
                compare_value({label, " data"}, e.data, result_data);
            end
            compare_value({label, " request_alt_pc"}, 32'(e.take), 32'(request_alt_pc));
            if (e.take) begin
                compare_value({label, " alt_pc"}, e.alt_pc, alt_pc);
            end
            compare_value({label, " illegal_instr"}, 32'(e.illegal), 32'(illegal_instr));
        end
    endtask

    task automatic print_summary();
        $display("Checks: %0d, value errors: %0d, other errors: %0d",
                 checks, value_errors, other_errors);
    endtask

    // Retire monitor on the falling edge
    always @(negedge CLK) begin
        if (RESET) begin
            if (result_valid) begin
                retire_check();
            end else begin
                compare_value("no result request_alt_pc", '0, 32'(request_alt_pc));
                compare_value("no result illegal_instr", '0, 32'(illegal_instr));
            end
        end
    end

    initial begin
        #(LIMIT_CYCLES * CLK_PERIOD);
        other_errors++;
        $display("Watchdog expired after %0d cycles with %0d results still outstanding",
                 LIMIT_CYCLES, expect_q.size());
        print_summary();
        $display("Simulation FAILED");
        $finish;
    end

    // **************************************************************************
    // Test sequence
    // **************************************************************************
    initial begin
        RESET        = 1'b0;
        instr_valid  = 1'b0;
        instr        = '0;
        instr_pc     = '0;
        lfsr         = LFSR_SEED;
        next_pc      = 32'h0040_0000;
        issued       = 0;
        checks       = 0;
        value_errors = 0;
        other_errors = 0;
        test_name    = "reset";
        for (int i = 0; i < NUM_AREGS; i++) begin
            arch_regs[i] = '0;
        end
        repeat (RESET_CYCLES) @(negedge CLK);
        RESET = 1'b1;

        test_name = "idle";
        repeat (5) begin
            @(negedge CLK);
            compare_value("idle result_valid", '0, 32'(result_valid));
        end

        // Dependent chain followed by every kind of control transfer
        test_name = "directed";
        issue(enc_i(OP_LUI, 5'd0, 5'd1, 16'h8000));
        issue(enc_i(OP_ORI, 5'd1, 5'd1, 16'h1234));
        issue(enc_i(OP_ADDIU, 5'd0, 5'd2, 16'hfffb));
        issue(enc_r(FN_SLT, 5'd1, 5'd2, 5'd3, 5'd0));
        issue(enc_r(FN_SLL, 5'd0, 5'd2, 5'd4, 5'd4));
        issue(enc_r(FN_SRL, 5'd0, 5'd1, 5'd5, 5'd3));
        issue(enc_r(FN_SUBU, 5'd5, 5'd4, 5'd6, 5'd0));
        issue(enc_i(OP_BEQ, 5'd1, 5'd1, 16'h0002));
        issue(enc_i(OP_BNE, 5'd1, 5'd2, 16'hfffc));
        issue(enc_j(OP_JAL, 26'h000_0100));
        issue(enc_r(FN_JR, 5'd31, 5'd0, 5'd0, 5'd0));
        issue(enc_j(OP_J, 26'h3ff_ffff));
        issue(enc_r(FN_ADDU, 5'd1, 5'd2, 5'd0, 5'd0));
        issue(enc_r(FN_ADDU, 5'd0, 5'd0, 5'd7, 5'd0));

        test_name = "random";
        for (int n = 0; n < NUM_RANDOM; n++) begin
            if (3'(lfsr_take(3)) == 3'd0) begin
                idle_cycle();
            end
            issue(random_instr());
        end

        // Copy each register onto itself to expose the final state
        test_name = "readout";
        for (int r = 1; r < NUM_AREGS; r++) begin
            issue(enc_r(FN_ADDU, areg_t'(r), 5'd0, areg_t'(r), 5'd0));
        end
        idle_cycle();

        while (expect_q.size() != 0) begin
            @(negedge CLK);
        end
        repeat (4) @(negedge CLK);

        print_summary();
        if (value_errors + other_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
